// File: filelist.f
+incdir+logic
logic/axis_pipe_pkg.sv
logic/data_pipe_force_vld.sv
logic/axis_packet_limiter.sv
logic/axis_pipe_top.sv
verif/axis_pipe_properties.sv
verif/tb_axis_pipe.sv

// File: logic/axis_packet_limiter.sv
// packet length limiter that forces last at the maximum burst and flags the split.
`timescale 1ns/1ps
`include "axis_pipe_settings.svh"
`default_nettype none

module axis_packet_limiter
    import axis_pipe_pkg::*;
(
    input  logic           axis_master_inf,
    input  logic           rst_n,
    input  logic           in_valid,
    input  axis_in_beat_t  in_beat,
    output logic           in_ready,
    output logic           out_valid,
    output axis_out_beat_t out_beat,
    input  logic           out_ready
);

    // counter sizing.
    localparam int cnt_w = `AXP_CNT_W;

    // index of the last beat allowed in one packet.
    localparam logic [cnt_w-1:0] last_idx = cnt_w'(`AXP_MAX_BURST - 1);

    // ====================
    // beat counter
    // ====================

    // beats already sent in the packet now open.
    logic [cnt_w-1:0] beat_cnt;

    // current beat is the final one allowed.
    logic             at_limit;

    // handshake on the output side.
    logic             out_fire;

    // ====================
    // handshake pass-through
    // ====================

    // no storage here, valid and ready pass straight through.
    assign out_valid = in_valid;
    assign in_ready  = out_ready;

    assign out_fire = out_valid & out_ready;

    // ====================
    // beat rewrite
    // ====================

    always_comb begin
        at_limit = (beat_cnt == last_idx);

        // data is never touched.
        out_beat.data = in_beat.data;

        // close on the source last or on the length limit.
        out_beat.last = in_beat.last | at_limit;

        // only a close the source did not ask for is flagged.
        out_beat.user = at_limit & ~in_beat.last;
    end

    // ====================
    // counter update
    // ====================

    // advances only when the beat really leaves.
    // any beat sent with last set opens a new packet.
    always_ff @(posedge axis_master_inf or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt <= '0;
        end else if (out_fire) begin
            if (out_beat.last) begin
                beat_cnt <= '0;
            end else begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    // after a forced split the rest of the source packet.
    // continues as a fresh output packet with a zero count.

endmodule

`default_nettype wire

// File: logic/axis_pipe_pkg.sv
// beat struct types shared by the pipeline RTL and its testbench.
`include "axis_pipe_settings.svh"
`default_nettype none

package axis_pipe_pkg;

    // ====================
    // input side
    // ====================

    // one beat as it arrives on the input stream.
    // last closes the packet as the source sees it.
    typedef struct packed {
        logic [`AXP_DATA_W-1:0] data;
        logic                   last;
    } axis_in_beat_t;

    // ====================
    // output side
    // ====================

    // one beat as it leaves the limiter and the output slice.
    // last is the source last or a forced close at the length limit.
    // user marks a close that the limiter added on its own.
    typedef struct packed {
        logic [`AXP_DATA_W-1:0] data;
        logic                   last;
        logic                   user;
    } axis_out_beat_t;

    // the data field keeps its position in both structs.
    // the user bit sits below last, so the lsb side is the only difference.
    // both types travel as plain packed vectors between the blocks.

endpackage

`default_nettype wire

// File: logic/axis_pipe_settings.svh
// width, packet length and skid buffer constants of the stream pipeline.
`ifndef AXIS_PIPE_SETTINGS_SVH
`define AXIS_PIPE_SETTINGS_SVH

`default_nettype none

// ====================
// stream payload
// ====================

// data bits carried by every beat.
`define AXP_DATA_W 8

// ====================
// packet limiter
// ====================

// longest packet allowed on the output, in beats (at least 2).
`define AXP_MAX_BURST 16

// beat counter width, counts 0 .. AXP_MAX_BURST-1.
`define AXP_CNT_W $clog2(`AXP_MAX_BURST)

// ====================
// register slice
// ====================

// entries held by one slice, main register plus skid register.
`define AXP_SKID_DEPTH 2

// occupancy counter width, counts 0 .. AXP_SKID_DEPTH.
`define AXP_FILL_W $clog2(`AXP_SKID_DEPTH + 1)

`default_nettype wire

`endif

// File: logic/axis_pipe_top.sv
// top level chaining the input slice, the packet limiter and the output slice.
`timescale 1ns/1ps
`default_nettype none

module axis_pipe_top
    import axis_pipe_pkg::*;
(
    input  logic           axis_master_inf,
    input  logic           rst_n,
    input  logic           in_valid,
    input  axis_in_beat_t  in_beat,
    output logic           in_ready,
    output logic           out_valid,
    output axis_out_beat_t out_beat,
    input  logic           out_ready
);

    // ====================
    // internal links
    // ====================

    // input slice to limiter.
    logic           mid_valid;
    axis_in_beat_t  mid_beat;
    logic           mid_ready;

    // limiter to output slice.
    logic           lim_valid;
    axis_out_beat_t lim_beat;
    logic           lim_ready;

    // ====================
    // input slice
    // ====================

    // one cycle of latency, registered ready towards the source.
    data_pipe_force_vld #(
        .beat_t    (axis_in_beat_t)
    ) u_in_slice (
        .axis_master_inf (axis_master_inf),
        .rst_n           (rst_n),
        .in_valid        (in_valid),
        .in_beat         (in_beat),
        .in_ready        (in_ready),
        .out_valid       (mid_valid),
        .out_beat        (mid_beat),
        .out_ready       (mid_ready)
    );

    // ====================
    // packet limiter
    // ====================

    // zero cycles, mid_ready is the output slice ready.
    axis_packet_limiter u_limiter (
        .axis_master_inf (axis_master_inf),
        .rst_n           (rst_n),
        .in_valid        (mid_valid),
        .in_beat         (mid_beat),
        .in_ready        (mid_ready),
        .out_valid       (lim_valid),
        .out_beat        (lim_beat),
        .out_ready       (lim_ready)
    );

    // ====================
    // output slice
    // ====================

    // second cycle of latency, registered valid to the sink.
    data_pipe_force_vld #(
        .beat_t    (axis_out_beat_t)
    ) u_out_slice (
        .axis_master_inf (axis_master_inf),
        .rst_n           (rst_n),
        .in_valid        (lim_valid),
        .in_beat         (lim_beat),
        .in_ready        (lim_ready),
        .out_valid       (out_valid),
        .out_beat        (out_beat),
        .out_ready       (out_ready)
    );

endmodule

`default_nettype wire

// File: logic/data_pipe_force_vld.sv
// two-entry skid register slice with registered valid and registered ready.
`timescale 1ns/1ps
`include "axis_pipe_settings.svh"
`default_nettype none

module data_pipe_force_vld
    import axis_pipe_pkg::*;
#(
    parameter type beat_t = axis_in_beat_t
) (
    input  logic  axis_master_inf,
    input  logic  rst_n,
    input  logic  in_valid,
    input  beat_t in_beat,
    output logic  in_ready,
    output logic  out_valid,
    output beat_t out_beat,
    input  logic  out_ready
);

    // occupancy counter sizing.
    localparam int fill_w = `AXP_FILL_W;
    localparam logic [fill_w-1:0] depth_c = fill_w'(`AXP_SKID_DEPTH);

    // ====================
    // storage
    // ====================

    // main register, drives the output directly.
    logic  main_vld;
    beat_t main_beat;

    // skid register, catches the beat in flight during a stall.
    logic  skid_vld;
    beat_t skid_beat;

    // registered ready towards the upstream.
    logic  rdy_q;

    // ====================
    // next state
    // ====================

    logic                in_fire;
    logic                out_fire;
    logic                main_free;
    logic                main_from_skid;
    logic                main_load;
    logic                skid_load;
    logic                main_vld_n;
    logic                skid_vld_n;
    logic [fill_w-1:0]   fill_n;
    logic                rdy_n;

    always_comb begin
        // transfers on both sides of the slice.
        in_fire  = in_valid & rdy_q;
        out_fire = main_vld & out_ready;

        // main register may take a new beat this cycle.
        main_free = ~main_vld | out_fire;

        // the skid entry is older, so it goes first.
        main_from_skid = main_free & skid_vld;
        main_load      = main_free & (skid_vld | in_fire);

        // incoming beat parks in skid when main cannot take it.
        skid_load = in_fire & (~main_free | skid_vld);

        // occupancy after this edge.
        main_vld_n = main_free ? (skid_vld | in_fire) : 1'b1;
        if (skid_load) begin
            skid_vld_n = 1'b1;
        end else if (main_from_skid) begin
            skid_vld_n = 1'b0;
        end else begin
            skid_vld_n = skid_vld;
        end

        // ready stays up while at least one entry is free.
        fill_n = fill_w'(main_vld_n) + fill_w'(skid_vld_n);
        rdy_n  = (fill_n < depth_c);
    end

    // ====================
    // control flops
    // ====================

    always_ff @(posedge axis_master_inf or negedge rst_n) begin
        if (!rst_n) begin
            main_vld <= 1'b0;
            skid_vld <= 1'b0;
            // empty after reset, so take beats right away.
            rdy_q    <= 1'b1;
        end else begin
            main_vld <= main_vld_n;
            skid_vld <= skid_vld_n;
            rdy_q    <= rdy_n;
        end
    end

    // ====================
    // payload flops
    // ====================

    always_ff @(posedge axis_master_inf) begin
        // main refills from skid first, else bypasses the input.
        if (main_load) begin
            main_beat <= main_from_skid ? skid_beat : in_beat;
        end
        // skid only written on a stall or while it is drained.
        if (skid_load) begin
            skid_beat <= in_beat;
        end
    end

    // ====================
    // outputs
    // ====================

    // all three come straight from flops.
    assign out_valid = main_vld;
    assign out_beat  = main_beat;
    assign in_ready  = rdy_q;

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the stream pipeline testbench with Verilator.
set -e
set -o pipefail

cd "$(dirname "$0")"

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    --top-module tb_axis_pipe \
    -Mdir "$build_dir" \
    -f filelist.f

# A high error limit lets the testbench print its own summary.
"./$build_dir/Vtb_axis_pipe" +verilator+error+limit+1000000 | tee "$log_file"

if grep -q "Testbench failed" "$log_file"; then
    echo "simulation reported a failure, see $log_file"
    exit 1
fi

echo "simulation finished, log in $log_file"

// File: verif/axis_pipe_properties.sv
// concurrent assertions for reset values, output stability and input slice occupancy.
`timescale 1ns/1ps
`include "axis_pipe_settings.svh"
`default_nettype none

module axis_pipe_properties
    import axis_pipe_pkg::*;
(
    input logic           axis_master_inf,
    input logic           rst_n,
    input logic           in_ready,
    input logic           out_valid,
    input axis_out_beat_t out_beat,
    input logic           out_ready,
    input logic           in_main_vld,
    input logic           in_skid_vld
);

    // failed assertions so far, read at the end of the run.
    int unsigned fail_cnt = 0;

    // out_ready has been low at least once since reset.
    logic seen_stall;

    always_ff @(posedge axis_master_inf or negedge rst_n) begin
        if (!rst_n) begin
            seen_stall <= 1'b0;
        end else if (!out_ready) begin
            seen_stall <= 1'b1;
        end
    end

    // ====================
    // reset values
    // ====================

    a_reset_vals: assert property (@(posedge axis_master_inf)
        !rst_n |-> !out_valid && in_ready)
        else begin $error("out_valid high or in_ready low during reset"); fail_cnt++; end

    a_first_edge: assert property (@(posedge axis_master_inf)
        $rose(rst_n) |-> !out_valid && in_ready)
        else begin $error("out_valid high or in_ready low on first edge"); fail_cnt++; end

    // in_ready can only drop once the sink has pushed back.
    a_ready_fall: assert property (@(posedge axis_master_inf) disable iff (!rst_n)
        $fell(in_ready) |-> seen_stall)
        else begin $error("in_ready fell without any back-pressure"); fail_cnt++; end

    // ====================
    // output stability
    // ====================

    a_out_hold: assert property (@(posedge axis_master_inf) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_beat))
        else begin $error("output beat changed while stalled"); fail_cnt++; end

    // ====================
    // input slice state
    // ====================

    // skid entry is only used behind a full main register.
    a_skid_order: assert property (@(posedge axis_master_inf) disable iff (!rst_n)
        in_skid_vld |-> in_main_vld)
        else begin $error("skid entry held with empty main register"); fail_cnt++; end

    // ready is low exactly when both entries are taken.
    a_ready_fill: assert property (@(posedge axis_master_inf) disable iff (!rst_n)
        in_ready == !(in_main_vld && in_skid_vld))
        else begin $error("in_ready disagrees with slice occupancy"); fail_cnt++; end

endmodule

bind axis_pipe_top axis_pipe_properties u_props (
    .axis_master_inf (axis_master_inf),
    .rst_n           (rst_n),
    .in_ready        (in_ready),
    .out_valid       (out_valid),
    .out_beat        (out_beat),
    .out_ready       (out_ready),
    .in_main_vld     (u_in_slice.main_vld),
    .in_skid_vld     (u_in_slice.skid_vld)
);

`default_nettype wire

// File: verif/tb_axis_pipe.sv
// testbench for the stream pipeline, with lfsr packets, back-pressure and a reference queue.
`timescale 1ns/1ps
`include "axis_pipe_settings.svh"
`default_nettype none

module tb_axis_pipe
    import axis_pipe_pkg::*;
();

    // ====================
    // run constants
    // ====================

    localparam int          num_pkts   = 600;
    localparam int          max_len    = 40;
    localparam int          half_per   = 4;
    // edges of steady out_ready after which the pipe holds no backlog.
    localparam int unsigned steady_min = 8;
    // edges allowed for the pipe to empty once the source stops.
    localparam int unsigned drain_max  = 64;
    localparam logic [31:0] lfsr_seed  = 32'h571a;
    localparam logic [31:0] lfsr_taps  = 32'h80200003;

    // one accepted input beat, with its edge number and the out_ready run at that edge.
    typedef struct packed {
        logic [`AXP_DATA_W-1:0] data;
        logic                   last;
        int unsigned            cyc;
        int unsigned            run;
    } beat_rec_t;

    logic           axis_master_inf;
    logic           rst_n;
    logic           in_valid;
    axis_in_beat_t  in_beat;
    logic           in_ready;
    logic           out_valid;
    axis_out_beat_t out_beat;
    logic           out_ready;

    logic [31:0]    lfsr_state;
    beat_rec_t      exp_q[$];
    int unsigned    pkt_lens[num_pkts];
    bit             steady_pkt[num_pkts];
    int unsigned    total_beats;
    int unsigned    cycle_limit;
    int unsigned    cyc;
    int unsigned    hi_run;
    int unsigned    pkt_len;
    int unsigned    out_len;
    int unsigned    check_errors;
    bit             done;

    axis_pipe_top u_axis_pipe_top (
        .axis_master_inf (axis_master_inf),
        .rst_n           (rst_n),
        .in_valid        (in_valid),
        .in_beat         (in_beat),
        .in_ready        (in_ready),
        .out_valid       (out_valid),
        .out_beat        (out_beat),
        .out_ready       (out_ready)
    );

    // 8 ns clock.
    initial axis_master_inf = 1'b0;
    always #half_per axis_master_inf = ~axis_master_inf;

    // galois lfsr, one step for every bit handed out.
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        logic        fb;
        int          k;
        bits = '0;
        for (k = 0; k < n; k++) begin
            fb         = lfsr_state[0];
            lfsr_state = (lfsr_state >> 1) ^ (fb ? lfsr_taps : 32'h0);
            bits       = {bits[30:0], fb};
        end
        return bits;
    endfunction

    // out_ready is low on 3 of 8 cycles outside steady phases.
    task automatic drive_ready(input bit steady);
        logic [31:0] rnd;
        if (steady) begin
            out_ready = 1'b1;
        end else begin
            rnd       = take_bits(3);
            out_ready = (rnd[2:0] >= 3'd3);
        end
    endtask

    // one packet, a beat is held until it is taken.
    task automatic send_packet(input int unsigned len, input bit steady);
        logic [31:0] rnd;
        int unsigned sent;
        bit          busy;
        sent = 0;
        busy = 1'b0;
        while (sent < len) begin
            @(negedge axis_master_inf);
            drive_ready(steady);
            if (!busy) begin
                rnd = take_bits(2);
                // a gap on one cycle in four, none in steady phases.
                if (steady || rnd[1:0] != 2'b00) begin
                    rnd          = take_bits(`AXP_DATA_W);
                    in_valid     = 1'b1;
                    in_beat.data = rnd[`AXP_DATA_W-1:0];
                    in_beat.last = (sent == len - 1);
                    busy         = 1'b1;
                end else begin
                    in_valid = 1'b0;
                end
            end
            @(posedge axis_master_inf);
            if (busy && in_ready) begin
                busy = 1'b0;
                sent++;
            end
        end
    endtask

    // ====================
    // reference and checks
    // ====================

    always @(posedge axis_master_inf) begin : monitor
        beat_rec_t   ref_rec;
        int unsigned lat;
        bit          at_limit;
        bit          exp_last;
        bit          exp_user;
        if (rst_n) begin
            cyc++;
            hi_run = out_ready ? hi_run + 1 : 0;
            // with a long enough out_ready run the source is never held off.
            if (hi_run >= steady_min) begin
                assert (in_ready) else begin
                    $display("[ERROR] %0t: in_ready low after %0d ready cycles", $time, hi_run);
                    check_errors++;
                end
            end
            if (in_valid && in_ready) begin
                exp_q.push_back('{in_beat.data, in_beat.last, cyc, hi_run});
            end
            if (out_valid && out_ready) begin
                assert (exp_q.size() > 0) else begin
                    $display("[ERROR] %0t: output beat %h with nothing expected", $time,
                             out_beat.data);
                    check_errors++;
                end
                if (exp_q.size() > 0) begin
                    ref_rec  = exp_q.pop_front();
                    pkt_len++;
                    // an output packet closes at the source last or at the length limit.
                    at_limit = (pkt_len == `AXP_MAX_BURST);
                    exp_last = ref_rec.last || at_limit;
                    exp_user = at_limit && !ref_rec.last;
                    assert (out_beat.data == ref_rec.data) else begin
                        $display("[ERROR] %0t: data expected %h, got %h", $time,
                                 ref_rec.data, out_beat.data);
                        check_errors++;
                    end
                    assert (out_beat.last == exp_last && out_beat.user == exp_user) else begin
                        $display("[ERROR] %0t: last/user expected %b%b, got %b%b", $time,
                                 exp_last, exp_user, out_beat.last, out_beat.user);
                        check_errors++;
                    end
                    // the packet as the DUT closes it with its own last.
                    out_len++;
                    assert (out_len <= `AXP_MAX_BURST) else begin
                        $display("[ERROR] %0t: packet length expected at most %0d, got %0d",
                                 $time, `AXP_MAX_BURST, out_len);
                        check_errors++;
                    end
                    if (out_beat.last) begin
                        out_len = 0;
                    end
                    if (exp_last) begin
                        pkt_len = 0;
                    end
                    // two edges through the pipe while out_ready stayed high throughout.
                    lat = cyc - ref_rec.cyc;
                    if (ref_rec.run >= steady_min && hi_run == ref_rec.run + lat) begin
                        assert (lat == 2) else begin
                            $display("[ERROR] %0t: latency expected 2, got %0d", $time, lat);
                            check_errors++;
                        end
                    end
                end
            end
        end
    end

    // ====================
    // run control
    // ====================

    initial begin : watchdog
        int unsigned waited;
        waited = 0;
        wait (cycle_limit != 0);
        while (!done && waited < cycle_limit) begin
            @(posedge axis_master_inf);
            waited++;
        end
        if (!done) begin
            $display("timeout: run not finished after %0d cycles, %0d beats still expected",
                     waited, exp_q.size());
            $display("Testbench failed");
            $finish;
        end
    end

    initial begin : stimulus
        logic [31:0] rnd;
        int unsigned prop_errors;
        int unsigned drain;
        int          p;
        lfsr_state   = lfsr_seed;
        rst_n        = 1'b1;
        in_valid     = 1'b0;
        in_beat      = '0;
        out_ready    = 1'b1;
        cyc          = 0;
        hi_run       = 0;
        pkt_len      = 0;
        out_len      = 0;
        check_errors = 0;
        done         = 1'b0;
        total_beats  = 0;
        cycle_limit  = 0;
        // packet lengths and phases first, so the limit is known up front.
        for (p = 0; p < num_pkts; p++) begin
            rnd           = take_bits(6);
            pkt_lens[p]   = (rnd % max_len) + 1;
            rnd           = take_bits(2);
            steady_pkt[p] = (rnd[1:0] == 2'b00);
            total_beats   = total_beats + pkt_lens[p];
        end
        cycle_limit = 4 * total_beats + 1000;
        // falling edge on rst_n starts the asynchronous reset.
        #1 rst_n = 1'b0;
        repeat (10) @(posedge axis_master_inf);
        @(negedge axis_master_inf);
        rst_n = 1'b1;
        for (p = 0; p < num_pkts; p++) begin
            send_packet(pkt_lens[p], steady_pkt[p]);
        end
        @(negedge axis_master_inf);
        in_valid  = 1'b0;
        out_ready = 1'b1;
        // the pipe holds only a few beats, so it empties well inside the bound.
        drain = 0;
        while (exp_q.size() != 0 && drain < drain_max) begin
            @(posedge axis_master_inf);
            drain++;
        end
        // idle tail catches any extra output beat.
        repeat (10) @(negedge axis_master_inf);
        done = 1'b1;
        assert (exp_q.size() == 0) else begin
            $display("[ERROR] %0t: %0d beats never came out", $time, exp_q.size());
            check_errors++;
        end
        prop_errors = u_axis_pipe_top.u_props.fail_cnt;
        $display("summary: %0d check errors, %0d property failures, %0d beats in %0d packets",
                 check_errors, prop_errors, total_beats, num_pkts);
        if (check_errors == 0 && prop_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
